// File: verilog.f
src/gpu_pkg.sv
src/core_control_regs.sv
src/core_scheduler.sv
src/instr_decoder.sv
src/alu.sv
src/pc.sv
src/register_file.sv
src/program_memory.sv
src/compute_core.sv
verif/tb_compute_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the compute core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_compute_core -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_compute_core > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0

// File: verif/tb_compute_core.sv
// Compute core testbench: in-order credit memory model, reference interpreter and result checks
`timescale 1ns/10ps

module tb_compute_core;

    // A single credit makes every slow request hold the next one back in REQUEST
    localparam int MEM_CREDITS = 1;
    localparam int MAX_LATENCY = 6;

    logic        clk = 1'b0;
    logic        reset;
    logic        prog_write;
    logic [7:0]  prog_addr;
    logic [15:0] prog_data;
    logic        cfg_write;
    logic [1:0]  cfg_addr;
    logic [7:0]  cfg_wdata;
    logic [7:0]  cfg_rdata;
    logic        mem_req_valid;
    logic        mem_req_write;
    logic [7:0]  mem_req_addr;
    logic [7:0]  mem_req_wdata;
    logic        mem_credit_return;
    logic        mem_rsp_valid;
    logic [7:0]  mem_rsp_data;

    // Program image shared by the DUT loader and the reference interpreter
    logic [15:0] program_image [256];
    logic [7:0]  data_mem [256];
    logic [7:0]  ref_mem [256];
    // Requests in flight, oldest at index 0
    logic        q_write [$];
    logic [7:0]  q_addr [$];
    logic [7:0]  q_wdata [$];
    int          q_wait [$];
    // Requests whose credit the core has not yet got back
    int          outstanding = 0;
    int unsigned lcg_state = 71;
    int          next_slot = 0;
    int          cycle_count = 0;
    // Reset, program load and the status read, later raised per program
    int          cycle_limit = 400;

    compute_core #(.MEM_CREDITS(MEM_CREDITS)) compute_core_inst (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else report_failure($sformatf("mismatch %s expected %0d actual %0d",
                                      name, expected, actual));
    endtask

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Low byte is {rs, rt} in the register format or the immediate otherwise
    task automatic add_instr(input gpu_pkg::opcode_t op, input logic [3:0] rd,
                             input logic [7:0] low);
        program_image[next_slot] = {op, rd, low};
        next_slot++;
    endtask

    task automatic build_programs();
        // Arithmetic at 0, results stored back to back at 0x80..0x84
        next_slot = 0;
        add_instr(gpu_pkg::CONST, 1, 8'd200);
        add_instr(gpu_pkg::CONST, 2, 8'd7);
        add_instr(gpu_pkg::CONST, 3, 8'd0);
        add_instr(gpu_pkg::ADD, 4, 8'h12);
        add_instr(gpu_pkg::SUB, 5, 8'h21);
        add_instr(gpu_pkg::MUL, 6, 8'h12);
        add_instr(gpu_pkg::DIV, 7, 8'h12);
        add_instr(gpu_pkg::DIV, 8, 8'h13);
        for (int r = 10; r < 15; r++)
            add_instr(gpu_pkg::CONST, 4'(r), 8'(8'h76 + r));
        add_instr(gpu_pkg::STR, 0, 8'hA4);
        add_instr(gpu_pkg::STR, 0, 8'hB5);
        add_instr(gpu_pkg::STR, 0, 8'hC6);
        add_instr(gpu_pkg::STR, 0, 8'hD7);
        add_instr(gpu_pkg::STR, 0, 8'hE8);
        add_instr(gpu_pkg::RET, 0, 8'h00);
        // Counted loop at 32; the loop body starts at 37 and each mask bit gets a branch
        next_slot = 32;
        add_instr(gpu_pkg::CONST, 1, 8'd0);
        add_instr(gpu_pkg::CONST, 2, 8'd5);
        add_instr(gpu_pkg::CONST, 3, 8'd1);
        add_instr(gpu_pkg::CONST, 4, 8'h90);
        add_instr(gpu_pkg::CONST, 5, 8'd0);
        add_instr(gpu_pkg::ADD, 5, 8'h51);
        add_instr(gpu_pkg::ADD, 1, 8'h13);
        add_instr(gpu_pkg::CMP, 0, 8'h12);
        add_instr(gpu_pkg::BRNZP, 4'b0001, 8'd37);
        add_instr(gpu_pkg::BRNZP, 4'b0010, 8'd43);
        add_instr(gpu_pkg::RET, 0, 8'h00);
        add_instr(gpu_pkg::STR, 0, 8'h45);
        add_instr(gpu_pkg::CMP, 0, 8'h23);
        add_instr(gpu_pkg::BRNZP, 4'b0100, 8'd47);
        add_instr(gpu_pkg::RET, 0, 8'h00);
        add_instr(gpu_pkg::ADD, 4, 8'h43);
        add_instr(gpu_pkg::STR, 0, 8'h41);
        add_instr(gpu_pkg::RET, 0, 8'h00);
        // Loads at 64, including a load right behind a posted store to the same word
        next_slot = 64;
        add_instr(gpu_pkg::CONST, 1, 8'h80);
        add_instr(gpu_pkg::CONST, 2, 8'hB0);
        add_instr(gpu_pkg::CONST, 3, 8'd3);
        add_instr(gpu_pkg::CONST, 11, 8'h40);
        add_instr(gpu_pkg::LDR, 4, 8'h10);
        add_instr(gpu_pkg::LDR, 12, 8'hB0);
        add_instr(gpu_pkg::MUL, 5, 8'h43);
        add_instr(gpu_pkg::ADD, 5, 8'h5C);
        add_instr(gpu_pkg::STR, 0, 8'h25);
        add_instr(gpu_pkg::LDR, 6, 8'h20);
        add_instr(gpu_pkg::ADD, 7, 8'h63);
        add_instr(gpu_pkg::STR, 0, 8'h17);
        add_instr(gpu_pkg::LDR, 8, 8'h10);
        add_instr(gpu_pkg::ADD, 9, 8'h23);
        add_instr(gpu_pkg::STR, 0, 8'h98);
        add_instr(gpu_pkg::RET, 0, 8'h00);
        // A burst of stores at 96 to run the core out of credits
        next_slot = 96;
        for (int r = 1; r < 5; r++)
            add_instr(gpu_pkg::CONST, 4'(r), 8'(8'h9F + r));
        add_instr(gpu_pkg::CONST, 5, 8'h5A);
        add_instr(gpu_pkg::STR, 0, 8'h15);
        add_instr(gpu_pkg::STR, 0, 8'h25);
        add_instr(gpu_pkg::STR, 0, 8'h35);
        add_instr(gpu_pkg::STR, 0, 8'h45);
        add_instr(gpu_pkg::STR, 0, 8'h11);
        add_instr(gpu_pkg::STR, 0, 8'h22);
        add_instr(gpu_pkg::RET, 0, 8'h00);
    endtask

    // Interprets one program on ref_mem and returns how many instructions retire
    function automatic int run_reference(input logic [7:0] start);
        logic [7:0]  regs [16];
        logic [2:0]  nzp;
        logic [15:0] word;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  pc;
        int          retired;
        bit          running;
        for (int i = 0; i < 16; i++)
            regs[i] = '0;
        nzp = '0;
        pc = start;
        retired = 0;
        running = 1'b1;
        while (running && retired < 1000) begin
            word = program_image[pc];
            a = regs[word[7:4]];
            b = regs[word[3:0]];
            retired++;
            pc = pc + 8'd1;
            case (word[15:12])
                gpu_pkg::BRNZP: if ((nzp & word[10:8]) != 3'b000) pc = word[7:0];
                gpu_pkg::CMP:   nzp = {a > b, a == b, a < b};
                gpu_pkg::ADD:   regs[word[11:8]] = a + b;
                gpu_pkg::SUB:   regs[word[11:8]] = a - b;
                gpu_pkg::MUL:   regs[word[11:8]] = a * b;
                gpu_pkg::DIV:   regs[word[11:8]] = (b == 8'd0) ? 8'd0 : a / b;
                gpu_pkg::LDR:   regs[word[11:8]] = ref_mem[a];
                gpu_pkg::STR:   ref_mem[a] = b;
                gpu_pkg::CONST: regs[word[11:8]] = word[7:0];
                gpu_pkg::RET:   running = 1'b0;
                default: ;
            endcase
        end
        return retired;
    endfunction

    task automatic load_programs();
        for (int a = 0; a < 256; a++) begin
            prog_write = 1'b1;
            prog_addr = 8'(a);
            prog_data = program_image[a];
            @(posedge clk);
            #2;
        end
        prog_write = 1'b0;
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
        cfg_write = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(posedge clk);
        #2;
        cfg_write = 1'b0;
    endtask

    // Readback is combinational, so it is sampled mid-cycle
    task automatic read_cfg(input logic [1:0] addr, output logic [7:0] data);
        cfg_addr = addr;
        @(negedge clk);
        data = cfg_rdata;
        @(posedge clk);
        #2;
    endtask

    task automatic run_program(input string name, input logic [7:0] start);
        int         expected_count;
        logic [7:0] value;
        expected_count = run_reference(start);
        cycle_limit += 2 * expected_count * (6 + MAX_LATENCY) + 80;
        write_cfg(2'd0, start);
        write_cfg(2'd1, 8'h01);
        read_cfg(2'd1, value);
        check_value({name, " status after launch"}, 1, int'(value));
        cfg_addr = 2'd1;
        do
            @(negedge clk);
        while (cfg_rdata[1] !== 1'b1);
        check_value({name, " status at done"}, 2, int'(cfg_rdata));
        @(posedge clk);
        #2;
        read_cfg(2'd2, value);
        check_value({name, " retire count"}, expected_count, int'(value));
        // Posted stores can still be in flight after RET retires
        while (q_addr.size() != 0)
            @(negedge clk);
        for (int a = 0; a < 256; a++)
            check_value($sformatf("%s mem[%0h]", name, a), int'(ref_mem[a]), int'(data_mem[a]));
        @(posedge clk);
        #2;
    endtask

    // In-order memory: requests are sampled mid-cycle, served after a random latency
    initial begin
        mem_credit_return = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        forever begin
            @(negedge clk);
            if (mem_req_valid && !reset) begin
                assert (outstanding < MEM_CREDITS)
                else report_failure("memory request seen while every credit was outstanding");
                outstanding++;
                q_write.push_back(mem_req_write);
                q_addr.push_back(mem_req_addr);
                q_wdata.push_back(mem_req_wdata);
                q_wait.push_back(1 + int'((next_random() >> 8) % MAX_LATENCY));
            end
            @(posedge clk);
            // A credit pulsed in the last cycle belongs to the core again from this edge
            if (mem_credit_return) begin
                outstanding--;
            end
            #2;
            mem_credit_return = 1'b0;
            mem_rsp_valid = 1'b0;
            if (q_addr.size() != 0) begin
                q_wait[0] = q_wait[0] - 1;
                if (q_wait[0] == 0) begin
                    if (q_write[0]) begin
                        data_mem[q_addr[0]] = q_wdata[0];
                    end else begin
                        mem_rsp_valid = 1'b1;
                        mem_rsp_data = data_mem[q_addr[0]];
                    end
                    // One credit comes back per finished request
                    mem_credit_return = 1'b1;
                    void'(q_write.pop_front());
                    void'(q_addr.pop_front());
                    void'(q_wdata.pop_front());
                    void'(q_wait.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < cycle_limit)
        else report_failure("timeout, the core did not finish within the cycle limit");
    end

    initial begin
        logic [7:0] status;
        reset = 1'b1;
        prog_write = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        // Fill pattern depends on every address bit
        for (int a = 0; a < 256; a++) begin
            program_image[a] = '0;
            data_mem[a] = 8'(a * 37 + 11);
            ref_mem[a] = 8'(a * 37 + 11);
        end
        build_programs();
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        read_cfg(2'd1, status);
        check_value("status after reset", 0, int'(status));
        load_programs();
        // Every launch after the first starts at a new PC and clears the retire count
        run_program("arith", 8'd0);
        run_program("branch", 8'd32);
        run_program("loads", 8'd64);
        run_program("credit_burst", 8'd96);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: src/compute_core.sv
// Compute core top level: ties the scheduler, datapath and memories to the external ports
`timescale 1ns/10ps

module compute_core #(
    parameter int DATA_BITS         = 8,
    parameter int PROGRAM_ADDR_BITS = 8,
    parameter int DATA_ADDR_BITS    = 8,
    parameter int MEM_CREDITS       = 2
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           prog_write,
    input  logic [PROGRAM_ADDR_BITS-1:0]   prog_addr,
    input  logic [gpu_pkg::INSTR_BITS-1:0] prog_data,
    input  logic                           cfg_write,
    input  logic [1:0]                     cfg_addr,
    input  logic [PROGRAM_ADDR_BITS-1:0]   cfg_wdata,
    output logic [PROGRAM_ADDR_BITS-1:0]   cfg_rdata,
    output logic                           mem_req_valid,
    output logic                           mem_req_write,
    output logic [DATA_ADDR_BITS-1:0]      mem_req_addr,
    output logic [DATA_BITS-1:0]           mem_req_wdata,
    input  logic                           mem_credit_return,
    input  logic                           mem_rsp_valid,
    input  logic [DATA_BITS-1:0]           mem_rsp_data
);

    gpu_pkg::core_state_t                  core_state;
    gpu_pkg::opcode_t                      alu_op;
    logic [gpu_pkg::INSTR_BITS-1:0]        instruction;
    logic [PROGRAM_ADDR_BITS-1:0]          start_pc, current_pc, next_pc, retired_count;
    logic                                  launch, busy, done;
    logic [$clog2(gpu_pkg::REG_COUNT)-1:0] rd, rs, rt;
    logic [DATA_BITS-1:0]                  decoded_immediate, alu_out, rs_data, rt_data;
    logic [2:0]                            decoded_nzp;
    logic                                  decoded_reg_write, decoded_mem_read;
    logic                                  decoded_mem_write, decoded_nzp_write_enable;
    logic                                  decoded_pc_mux, decoded_ret;
    logic [1:0]                            reg_input_sel;

    // STR addresses memory through rs and sends rt as data, LDR uses rs only
    assign mem_req_write = decoded_mem_write;
    assign mem_req_addr  = DATA_ADDR_BITS'(rs_data);
    assign mem_req_wdata = rt_data;

    core_control_regs #(.PROGRAM_ADDR_BITS(PROGRAM_ADDR_BITS)) core_control_regs_inst (
        .clk, .reset, .cfg_write, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .busy, .done, .retired_count, .start_pc, .launch
    );

    core_scheduler #(
        .PROGRAM_ADDR_BITS(PROGRAM_ADDR_BITS),
        .MEM_CREDITS      (MEM_CREDITS)
    ) core_scheduler_inst (
        .clk, .reset, .launch, .start_pc, .decoded_mem_read, .decoded_mem_write,
        .decoded_ret, .mem_credit_return, .mem_rsp_valid, .next_pc, .core_state,
        .current_pc, .mem_req_valid, .busy, .done, .retired_count
    );

    program_memory #(.PROGRAM_ADDR_BITS(PROGRAM_ADDR_BITS)) program_memory_inst (
        .clk, .prog_write, .prog_addr, .prog_data, .fetch_addr(current_pc), .instruction
    );

    instr_decoder #(.DATA_BITS(DATA_BITS)) instr_decoder_inst (
        .clk, .reset, .core_state, .instruction, .rd, .rs, .rt, .decoded_immediate,
        .decoded_nzp, .alu_op, .decoded_reg_write, .decoded_mem_read, .decoded_mem_write,
        .decoded_nzp_write_enable, .decoded_pc_mux, .decoded_ret, .reg_input_sel
    );

    register_file #(.DATA_BITS(DATA_BITS)) register_file_inst (
        .clk, .reset, .core_state, .rd, .rs, .rt, .decoded_reg_write, .reg_input_sel,
        .alu_out, .mem_rsp_data, .decoded_immediate, .rs_data, .rt_data
    );

    alu #(.DATA_BITS(DATA_BITS)) alu_inst (
        .clk, .reset, .core_state, .alu_op, .rs_data, .rt_data, .alu_out
    );

    // The PC block advances only while the core is busy
    pc #(
        .DATA_BITS        (DATA_BITS),
        .PROGRAM_ADDR_BITS(PROGRAM_ADDR_BITS)
    ) pc_inst (
        .clk, .reset, .enable(busy), .core_state, .decoded_nzp, .decoded_immediate,
        .decoded_nzp_write_enable, .decoded_pc_mux, .alu_out, .current_pc, .next_pc
    );

endmodule

// File: src/program_memory.sv
// Instruction store with a host load port and a registered fetch read
`timescale 1ns/10ps

module program_memory #(
    parameter int PROGRAM_ADDR_BITS = 8
) (
    input  logic                           clk,
    input  logic                           prog_write,
    input  logic [PROGRAM_ADDR_BITS-1:0]   prog_addr,
    input  logic [gpu_pkg::INSTR_BITS-1:0] prog_data,
    input  logic [PROGRAM_ADDR_BITS-1:0]   fetch_addr,
    output logic [gpu_pkg::INSTR_BITS-1:0] instruction
);

    logic [gpu_pkg::INSTR_BITS-1:0] words [2**PROGRAM_ADDR_BITS];

    // The host loads words only while the core is idle, so the two ports never race
    always_ff @(posedge clk) begin
        if (prog_write) begin
            words[prog_addr] <= prog_data;
        end
        instruction <= words[fetch_addr];
    end

endmodule

// File: src/register_file.sv
// Register file: sixteen data registers, two combinational read ports and one write port
`timescale 1ns/10ps

module register_file #(
    parameter int DATA_BITS = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  gpu_pkg::core_state_t                  core_state,
    input  logic [$clog2(gpu_pkg::REG_COUNT)-1:0] rd,
    input  logic [$clog2(gpu_pkg::REG_COUNT)-1:0] rs,
    input  logic [$clog2(gpu_pkg::REG_COUNT)-1:0] rt,
    input  logic                                  decoded_reg_write,
    input  logic [1:0]                            reg_input_sel,
    input  logic [DATA_BITS-1:0]                  alu_out,
    input  logic [DATA_BITS-1:0]                  mem_rsp_data,
    input  logic [DATA_BITS-1:0]                  decoded_immediate,
    output logic [DATA_BITS-1:0]                  rs_data,
    output logic [DATA_BITS-1:0]                  rt_data
);

    logic [DATA_BITS-1:0] regs [gpu_pkg::REG_COUNT];
    logic [DATA_BITS-1:0] load_data;

    // WAIT ends on the response cycle, so the last sample taken here is the load data
    always_ff @(posedge clk) begin
        if (core_state == gpu_pkg::WAIT) begin
            load_data <= mem_rsp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < gpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (core_state == gpu_pkg::UPDATE && decoded_reg_write) begin
            case (reg_input_sel)
                gpu_pkg::REG_SEL_MEM: regs[rd] <= load_data;
                gpu_pkg::REG_SEL_IMM: regs[rd] <= decoded_immediate;
                default:              regs[rd] <= alu_out;
            endcase
        end
    end

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

endmodule

// File: src/pc.sv
// Next-PC logic with the NZP condition register for BRnzp
`timescale 1ns/10ps

module pc #(
    parameter int DATA_BITS         = 8,
    parameter int PROGRAM_ADDR_BITS = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enable,
    input  gpu_pkg::core_state_t         core_state,
    input  logic [2:0]                   decoded_nzp,
    input  logic [DATA_BITS-1:0]         decoded_immediate,
    input  logic                         decoded_nzp_write_enable,
    input  logic                         decoded_pc_mux,
    input  logic [DATA_BITS-1:0]         alu_out,
    input  logic [PROGRAM_ADDR_BITS-1:0] current_pc,
    output logic [PROGRAM_ADDR_BITS-1:0] next_pc
);

    logic [2:0] nzp;

    // Enable is the core busy flag, so nothing moves while idle or done
    always_ff @(posedge clk) begin
        if (reset) begin
            nzp     <= 3'b000;
            next_pc <= '0;
        end else if (enable) begin
            if (core_state == gpu_pkg::EXECUTE) begin
                // Branch when any mask bit matches the flags left by the last CMP
                if (decoded_pc_mux && ((nzp & decoded_nzp) != 3'b000)) begin
                    next_pc <= PROGRAM_ADDR_BITS'(decoded_immediate);
                end else begin
                    next_pc <= current_pc + 1'b1;
                end
            end
            // The flags come straight from the registered compare result
            if (core_state == gpu_pkg::UPDATE && decoded_nzp_write_enable) begin
                nzp <= alu_out[2:0];
            end
        end
    end

endmodule

// File: src/alu.sv
// Arithmetic and compare unit, result registered during EXECUTE
`timescale 1ns/10ps

module alu #(
    parameter int DATA_BITS = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  gpu_pkg::core_state_t core_state,
    input  gpu_pkg::opcode_t     alu_op,
    input  logic [DATA_BITS-1:0] rs_data,
    input  logic [DATA_BITS-1:0] rt_data,
    output logic [DATA_BITS-1:0] alu_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_out <= '0;
        end else if (core_state == gpu_pkg::EXECUTE) begin
            case (alu_op)
                gpu_pkg::ADD: alu_out <= rs_data + rt_data;
                gpu_pkg::SUB: alu_out <= rs_data - rt_data;
                // Only the low half of the product is kept
                gpu_pkg::MUL: alu_out <= DATA_BITS'(rs_data * rt_data);
                gpu_pkg::DIV: begin
                    // A zero divisor yields zero rather than trapping
                    alu_out <= (rt_data == '0) ? '0 : rs_data / rt_data;
                end
                gpu_pkg::CMP: begin
                    // Bit 2 greater, bit 1 equal, bit 0 less
                    alu_out <= DATA_BITS'({rs_data > rt_data, rs_data == rt_data,
                                           rs_data < rt_data});
                end
                default: alu_out <= alu_out;
            endcase
        end
    end

endmodule

// File: src/instr_decoder.sv
// Instruction decoder: splits the fetched word into registered fields and control flags
`timescale 1ns/10ps

module instr_decoder #(
    parameter int DATA_BITS = 8
) (
    input  logic                               clk,
    input  logic                               reset,
    input  gpu_pkg::core_state_t               core_state,
    input  gpu_pkg::instr_t                    instruction,
    output logic [$clog2(gpu_pkg::REG_COUNT)-1:0] rd,
    output logic [$clog2(gpu_pkg::REG_COUNT)-1:0] rs,
    output logic [$clog2(gpu_pkg::REG_COUNT)-1:0] rt,
    output logic [DATA_BITS-1:0]               decoded_immediate,
    output logic [2:0]                         decoded_nzp,
    output gpu_pkg::opcode_t                   alu_op,
    output logic                               decoded_reg_write,
    output logic                               decoded_mem_read,
    output logic                               decoded_mem_write,
    output logic                               decoded_nzp_write_enable,
    output logic                               decoded_pc_mux,
    output logic                               decoded_ret,
    output logic [1:0]                         reg_input_sel
);

    // Operand fields are plain payload and only change in DECODE
    always_ff @(posedge clk) begin
        if (core_state == gpu_pkg::DECODE) begin
            rd                <= instruction.i.rd;
            rs                <= instruction.r.rs;
            rt                <= instruction.r.rt;
            decoded_immediate <= DATA_BITS'(instruction.i.imm);
            // The branch mask is the low three bits of the immediate format's rd field
            decoded_nzp       <= instruction.i.rd[2:0];
            alu_op            <= instruction.r.opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded_reg_write        <= 1'b0;
            decoded_mem_read         <= 1'b0;
            decoded_mem_write        <= 1'b0;
            decoded_nzp_write_enable <= 1'b0;
            decoded_pc_mux           <= 1'b0;
            decoded_ret              <= 1'b0;
            reg_input_sel            <= gpu_pkg::REG_SEL_ALU;
        end else if (core_state == gpu_pkg::DECODE) begin
            // Everything is cleared first so NOP and unknown opcodes do nothing
            decoded_reg_write        <= 1'b0;
            decoded_mem_read         <= 1'b0;
            decoded_mem_write        <= 1'b0;
            decoded_nzp_write_enable <= 1'b0;
            decoded_pc_mux           <= 1'b0;
            decoded_ret              <= 1'b0;
            reg_input_sel            <= gpu_pkg::REG_SEL_ALU;
            case (instruction.r.opcode)
                gpu_pkg::ADD, gpu_pkg::SUB, gpu_pkg::MUL, gpu_pkg::DIV: begin
                    decoded_reg_write <= 1'b1;
                end
                gpu_pkg::CMP:   decoded_nzp_write_enable <= 1'b1;
                gpu_pkg::BRNZP: decoded_pc_mux <= 1'b1;
                gpu_pkg::LDR: begin
                    decoded_reg_write <= 1'b1;
                    decoded_mem_read  <= 1'b1;
                    reg_input_sel     <= gpu_pkg::REG_SEL_MEM;
                end
                gpu_pkg::STR:   decoded_mem_write <= 1'b1;
                gpu_pkg::CONST: begin
                    decoded_reg_write <= 1'b1;
                    reg_input_sel     <= gpu_pkg::REG_SEL_IMM;
                end
                gpu_pkg::RET:   decoded_ret <= 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: src/core_scheduler.sv
// Core scheduler: instruction state machine, current PC, memory credits and retire counter
`timescale 1ns/10ps

module core_scheduler #(
    parameter int PROGRAM_ADDR_BITS = 8,
    parameter int MEM_CREDITS       = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         launch,
    input  logic [PROGRAM_ADDR_BITS-1:0] start_pc,
    input  logic                         decoded_mem_read,
    input  logic                         decoded_mem_write,
    input  logic                         decoded_ret,
    input  logic                         mem_credit_return,
    input  logic                         mem_rsp_valid,
    input  logic [PROGRAM_ADDR_BITS-1:0] next_pc,
    output gpu_pkg::core_state_t         core_state,
    output logic [PROGRAM_ADDR_BITS-1:0] current_pc,
    output logic                         mem_req_valid,
    output logic                         busy,
    output logic                         done,
    output logic [PROGRAM_ADDR_BITS-1:0] retired_count
);

    localparam int CREDIT_BITS = $clog2(MEM_CREDITS + 1);

    logic [CREDIT_BITS-1:0] credits;

    // A request goes out in any REQUEST cycle that still has a credit to spend
    assign mem_req_valid = (core_state == gpu_pkg::REQUEST) && (credits != '0);

    assign busy = (core_state != gpu_pkg::IDLE) && (core_state != gpu_pkg::DONE);
    assign done = (core_state == gpu_pkg::DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            core_state    <= gpu_pkg::IDLE;
            current_pc    <= '0;
            retired_count <= '0;
            credits       <= CREDIT_BITS'(MEM_CREDITS);
        end else begin
            // Returns and issues can land together, so both are applied every cycle
            credits <= credits + CREDIT_BITS'(mem_credit_return) - CREDIT_BITS'(mem_req_valid);

            case (core_state)
                gpu_pkg::IDLE, gpu_pkg::DONE: begin
                    // Done holds until software launches again
                    if (launch) begin
                        core_state    <= gpu_pkg::FETCH;
                        current_pc    <= start_pc;
                        retired_count <= '0;
                    end
                end
                gpu_pkg::FETCH: begin
                    core_state <= gpu_pkg::DECODE;
                end
                gpu_pkg::DECODE: begin
                    core_state <= gpu_pkg::EXECUTE;
                end
                gpu_pkg::EXECUTE: begin
                    // Decoded flags are valid from here on, so memory ops branch off now
                    if (decoded_mem_read || decoded_mem_write) begin
                        core_state <= gpu_pkg::REQUEST;
                    end else begin
                        core_state <= gpu_pkg::UPDATE;
                    end
                end
                gpu_pkg::REQUEST: begin
                    // Stores are posted, loads wait for their data
                    if (mem_req_valid) begin
                        core_state <= decoded_mem_read ? gpu_pkg::WAIT : gpu_pkg::UPDATE;
                    end
                end
                gpu_pkg::WAIT: begin
                    if (mem_rsp_valid) begin
                        core_state <= gpu_pkg::UPDATE;
                    end
                end
                gpu_pkg::UPDATE: begin
                    current_pc    <= next_pc;
                    retired_count <= retired_count + 1'b1;
                    core_state    <= decoded_ret ? gpu_pkg::DONE : gpu_pkg::FETCH;
                end
                default: begin
                    core_state <= gpu_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/core_control_regs.sv
// Configuration registers: start address, launch command, status and retire count readback
`timescale 1ns/10ps

module core_control_regs #(
    parameter int PROGRAM_ADDR_BITS = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cfg_write,
    input  logic [1:0]                   cfg_addr,
    input  logic [PROGRAM_ADDR_BITS-1:0] cfg_wdata,
    output logic [PROGRAM_ADDR_BITS-1:0] cfg_rdata,
    input  logic                         busy,
    input  logic                         done,
    input  logic [PROGRAM_ADDR_BITS-1:0] retired_count,
    output logic [PROGRAM_ADDR_BITS-1:0] start_pc,
    output logic                         launch
);

    // Start address is written at register 0 and kept across runs
    always_ff @(posedge clk) begin
        if (reset) begin
            start_pc <= '0;
        end else if (cfg_write && cfg_addr == 2'd0) begin
            start_pc <= cfg_wdata;
        end
    end

    // A write of bit 0 at register 1 launches the core on the following edge
    assign launch = cfg_write && (cfg_addr == 2'd1) && cfg_wdata[0];

    // Readback is combinational so the bus sees status in the same cycle
    always_comb begin
        case (cfg_addr)
            2'd0:    cfg_rdata = start_pc;
            2'd1:    cfg_rdata = PROGRAM_ADDR_BITS'({done, busy});
            2'd2:    cfg_rdata = retired_count;
            default: cfg_rdata = '0;
        endcase
    end

endmodule

// File: src/gpu_pkg.sv
// Shared core definitions: scheduler states, opcodes and the two-view instruction word
package gpu_pkg;

    // Width of one instruction word in program memory
    localparam int INSTR_BITS = 16;

    // Number of general purpose registers in the register file
    localparam int REG_COUNT = 16;

    // Source select for the register file write port
    localparam logic [1:0] REG_SEL_ALU = 2'd0;
    localparam logic [1:0] REG_SEL_MEM = 2'd1;
    localparam logic [1:0] REG_SEL_IMM = 2'd2;

    // Every instruction walks through a subset of these states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FETCH   = 3'd1,
        DECODE  = 3'd2,
        REQUEST = 3'd3,
        WAIT    = 3'd4,
        EXECUTE = 3'd5,
        UPDATE  = 3'd6,
        DONE    = 3'd7
    } core_state_t;

    // Top nibble of every instruction
    typedef enum logic [3:0] {
        NOP   = 4'h0,
        BRNZP = 4'h1,
        CMP   = 4'h2,
        ADD   = 4'h3,
        SUB   = 4'h4,
        MUL   = 4'h5,
        DIV   = 4'h6,
        LDR   = 4'h7,
        STR   = 4'h8,
        CONST = 4'h9,
        RET   = 4'hf
    } opcode_t;

    // Register format, used by the arithmetic, compare and memory instructions
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
    } instr_reg_t;

    // Immediate format, used by CONST and BRnzp (NZP mask sits in rd[2:0])
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] rd;
        logic [7:0] imm;
    } instr_imm_t;

    // Both views share the opcode and rd positions
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

endpackage
